// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= vn_xfer_tb
RTL_TOP    ?= vn_xfer_top
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: src/vn_apb_pkg.sv
/*
  Types seen from the APB side of the mover. Offsets are byte addresses
  within a VN_AW wide window. Only the listed offsets are mapped; the SRC
  and DST regions hold VN_DEPTH word-aligned entries each.
*/
package vn_apb_pkg;

`include "vn_cfg.svh"

  // ----------------------------------------------------------------------
  // Register map
  // ----------------------------------------------------------------------
  // CTRL takes the length in bits 4:1 and the start bit in bit 0
  // STATUS and DST are read-only
  typedef enum logic [`VN_AW-1:0] {
    CTRL     = 8'h00,
    STATUS   = 8'h04,
    SRC_BASE = 8'h20,
    DST_BASE = 8'h40
  } vn_reg_e;

  // Status word as it appears in the low bits of a STATUS read
  // Done is sticky until the next accepted start
  typedef struct packed {
    logic done;
    logic busy;
  } vn_status_t;

endpackage

// File: src/vn_apb_regs.sv
/*
  APB slave for the mover. No wait states; pready is tied high. Errored
  accesses have no effect and return zero. CTRL and SRC writes are refused
  while a transfer is pending or busy. Buffers are not reset.
*/
`timescale 1ns/1ps

`include "vn_cfg.svh"

module vn_apb_regs
  import vn_apb_pkg::*, vn_xfer_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [`VN_AW-1:0]    paddr,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [`VN_WIDTH-1:0] pwdata,
  output logic [`VN_WIDTH-1:0] prdata,
  output logic                 pready,
  output logic                 pslverr,
  vn_ctrl_if.regs              ctrl,
  input  logic                 send_valid_next,
  input  logic [`VN_IDX_W-1:0] send_idx,
  output vn_payload_t          src_payload,
  output logic                 src_valid_next,
  input  logic                 dst_valid_next,
  input  vn_payload_t          dst_payload
);

  localparam int AW = `VN_AW;
  localparam int IW = `VN_IDX_W;
  localparam logic [AW-1:0] SRC_ADDR = SRC_BASE;
  localparam logic [AW-1:0] DST_ADDR = DST_BASE;

  logic [`VN_WIDTH-1:0] src_mem [`VN_DEPTH];
  logic [`VN_WIDTH-1:0] dst_mem [`VN_DEPTH];
  logic [`VN_WIDTH-1:0] src_rd_data;
  logic [`VN_WIDTH-1:0] rdata;
  logic [IW-1:0]        src_rd_idx;
  logic [IW-1:0]        word_idx;
  logic [IW:0]          wr_len;
  logic [IW:0]          len_q;
  logic                 start_q;
  logic                 dst_we_q;
  logic                 access;
  logic                 hit_ctrl, hit_status, hit_src, hit_dst;
  logic                 busy_any, len_bad, err, wr_ok;
  vn_status_t           st;

  // ----------------------------------------------------------------------
  // Decode and error judgement
  // ----------------------------------------------------------------------
  assign access     = psel && penable;
  assign word_idx   = paddr[IW+1:2];
  assign wr_len     = pwdata[IW+1:1];
  assign hit_ctrl   = (paddr == CTRL);
  assign hit_status = (paddr == STATUS);
  assign hit_src    = (paddr[AW-1:IW+2] == SRC_ADDR[AW-1:IW+2]) && (paddr[1:0] == 2'b00);
  assign hit_dst    = (paddr[AW-1:IW+2] == DST_ADDR[AW-1:IW+2]) && (paddr[1:0] == 2'b00);

  // A start still in flight to the FSM counts as busy
  assign busy_any = ctrl.busy || start_q;
  assign len_bad  = (wr_len == '0) || (wr_len > (IW+1)'(`VN_DEPTH));

  assign err = !(hit_ctrl || hit_status || hit_src || hit_dst)
            || (pwrite && (hit_status || hit_dst))
            || (pwrite && hit_ctrl && (len_bad || busy_any))
            || (pwrite && hit_src && busy_any);

  assign wr_ok   = access && pwrite && !err;
  assign pready  = 1'b1;
  assign pslverr = access && err;

  // ----------------------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------------------
  assign st = '{busy: ctrl.busy, done: ctrl.done};

  always_comb begin
    rdata = '0;
    if (hit_ctrl) begin
      rdata[IW+1:1] = len_q;
    end else if (hit_status) begin
      rdata = `VN_WIDTH'(st);
    end else if (hit_src) begin
      rdata = src_mem[word_idx];
    end else if (hit_dst) begin
      rdata = dst_mem[word_idx];
    end
  end

  assign prdata = (access && !pwrite && !err) ? rdata : '0;

  // ----------------------------------------------------------------------
  // Control writes
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      start_q <= 1'b0;
      len_q   <= '0;
    end else begin
      // Start lasts exactly one cycle
      start_q <= wr_ok && hit_ctrl && pwdata[0];
      if (wr_ok && hit_ctrl) begin
        len_q <= wr_len;
      end
    end
  end

  assign ctrl.start  = start_q;
  assign ctrl.length = len_q;

  always_ff @(posedge clk) begin
    if (wr_ok && hit_src) begin
      src_mem[word_idx] <= pwdata;
    end
  end

  // Registered source read, so data trails its valid_next by one cycle
  always_ff @(posedge clk) begin
    if (send_valid_next) begin
      src_rd_data <= src_mem[send_idx];
      src_rd_idx  <= send_idx;
    end
  end

  assign src_valid_next = send_valid_next;
  assign src_payload    = '{idx: src_rd_idx, data: src_rd_data};

  // Far end: out word is valid the cycle after its valid_next
  always_ff @(posedge clk) begin
    if (reset) begin
      dst_we_q <= 1'b0;
    end else begin
      dst_we_q <= dst_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (dst_we_q) begin
      dst_mem[dst_payload.idx] <= dst_payload.data;
    end
  end

endmodule

// File: src/vn_cfg.svh
/*
  Build-time sizing for the burst mover. VN_IDX_W must equal
  $clog2(VN_DEPTH), and the APB map assumes VN_DEPTH words of four bytes
  fit below each region base. Changing VN_STAGES moves the done latency.
*/
`ifndef VN_CFG_SVH
`define VN_CFG_SVH

// Number of words in each of the source and destination buffers
`define VN_DEPTH 8

// Register stages in the valid-next transport
`define VN_STAGES 3

// Data word width, also the APB data width
`define VN_WIDTH 32

// APB byte address width
`define VN_AW 8

// Buffer index width
`define VN_IDX_W 3

`endif

// File: src/vn_ctrl_if.sv
/*
  Control handshake between the register block and the transfer FSM.
  Start is a single-cycle pulse and length must be valid while it is high.
  Busy and done are registered by the FSM.
*/
`timescale 1ns/1ps

`include "vn_cfg.svh"

interface vn_ctrl_if;

  // Pulsed by the register block on an accepted start
  logic                 start;
  // Word count of the transfer, 1 to VN_DEPTH
  logic [`VN_IDX_W:0]   length;
  // High from the cycle after start until the transfer has fully landed
  logic                 busy;
  // Sticky completion flag, cleared by the next start
  logic                 done;

  // Register block side
  modport regs (output start, output length, input busy, input done);

  // Transfer FSM side
  modport fsm (input start, input length, output busy, output done);

endinterface

// File: src/vn_delay_line.sv
/*
  Valid-next delay line. The payload is valid one cycle after its
  valid_next. Stages hold no reset and load only when their valid_next is
  high, so stale words remain between transfers. With NUM_STAGES = 0 the
  line is a plain connection. Reset is only observed by bound checks.
*/
`timescale 1ns/1ps

module vn_delay_line #(
  parameter type payload_t = logic,
  parameter int  NUM_STAGES = 0
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid_next,
  input  payload_t in,
  output logic     out_valid_next,
  output payload_t out
);

  // Index 0 is the input side, index NUM_STAGES the output side
  logic [NUM_STAGES:0] stage_valid_next;
  payload_t            stage [NUM_STAGES+1];

  assign stage_valid_next[0] = in_valid_next;
  assign stage[0]            = in;

  for (genvar i = 1; i <= NUM_STAGES; i++) begin : gen_stage
    // The valid_next bit simply walks down the line
    always_ff @(posedge clk) begin
      stage_valid_next[i] <= stage_valid_next[i-1];
    end

    // stage_valid_next[i] lines up with the word now sitting in stage i-1,
    // so it is the enable for copying that word forward
    always_ff @(posedge clk) begin
      if (stage_valid_next[i]) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign out_valid_next = stage_valid_next[NUM_STAGES];
  assign out            = stage[NUM_STAGES];

endmodule

// File: src/vn_word_counter.sv
/*
  Send counter and drain timer for the transfer FSM. Length must be
  between 1 and VN_DEPTH when load is high. The drain timer runs for
  VN_STAGES+2 cycles after drain_start.
*/
`timescale 1ns/1ps

`include "vn_cfg.svh"

module vn_word_counter (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 load,
  input  logic [`VN_IDX_W:0]   length,
  input  logic                 count_en,
  input  logic                 drain_start,
  output logic                 last_word,
  output logic                 drain_done,
  output logic [`VN_IDX_W-1:0] count
);

  // Source read, transport stages and destination capture
  localparam int DRAIN_CYC = `VN_STAGES + 2;
  localparam int TW        = $clog2(DRAIN_CYC + 1);

  logic [`VN_IDX_W:0] len_q;
  logic [TW-1:0]      drain_left;
  logic               drain_run;

  // ----------------------------------------------------------------------
  // Send phase
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      len_q <= '0;
    end else if (load) begin
      count <= '0;
      len_q <= length;
    end else if (count_en) begin
      // Wraps to zero after a full-depth transfer, harmless since load reopens
      count <= count + 1'b1;
    end
  end

  // Final word of the burst is the one whose index is length-1
  assign last_word = count_en && ({1'b0, count} == (len_q - 1'b1));

  // ----------------------------------------------------------------------
  // Drain phase
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      drain_run  <= 1'b0;
      drain_left <= '0;
    end else if (drain_start) begin
      drain_run  <= 1'b1;
      drain_left <= TW'(DRAIN_CYC - 1);
    end else if (drain_done) begin
      drain_run  <= 1'b0;
    end else if (drain_run) begin
      drain_left <= drain_left - 1'b1;
    end
  end

  assign drain_done = drain_run && (drain_left == '0);

endmodule

// File: src/vn_xfer_fsm.sv
/*
  Transfer FSM. Issues one valid_next and one source index per cycle for
  length cycles, then waits out the transport. Busy and done change on
  the same edge, length+VN_STAGES+3 cycles after start. A start is only
  honoured in IDLE.
*/
`timescale 1ns/1ps

`include "vn_cfg.svh"

module vn_xfer_fsm
  import vn_xfer_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  vn_ctrl_if.fsm               ctrl,
  output logic                 send_valid_next,
  output logic [`VN_IDX_W-1:0] send_idx
);

  vn_state_e state_q;
  vn_state_e state_d;
  logic      go;
  logic      last_word;
  logic      drain_done;
  logic      busy_q;
  logic      done_q;

  assign go = (state_q == IDLE) && ctrl.start;

  // ----------------------------------------------------------------------
  // State register and next state
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (ctrl.start) state_d = SEND;
      SEND:    if (last_word) state_d = DRAIN;
      DRAIN:   if (drain_done) state_d = FINISH;
      default: state_d = IDLE;
    endcase
  end

  // Busy rises with SEND and falls when the drain timer expires
  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else if (go) begin
      busy_q <= 1'b1;
      done_q <= 1'b0;
    end else if (drain_done) begin
      busy_q <= 1'b0;
      done_q <= 1'b1;
    end
  end

  assign ctrl.busy = busy_q;
  assign ctrl.done = done_q;

  // One word goes out every SEND cycle
  assign send_valid_next = (state_q == SEND);

  vn_word_counter u_counter (
    .clk         (clk),
    .reset       (reset),
    .load        (go),
    .length      (ctrl.length),
    .count_en    (send_valid_next),
    .drain_start (last_word),
    .last_word   (last_word),
    .drain_done  (drain_done),
    .count       (send_idx)
  );

endmodule

// File: src/vn_xfer_pkg.sv
/*
  Types for the transfer side: the word that rides the transport and the
  transfer FSM states. The payload carries its own destination index, so
  the far end needs no counter of its own.
*/
package vn_xfer_pkg;

`include "vn_cfg.svh"

  // One transported word plus where it lands in the destination buffer
  typedef struct packed {
    logic [`VN_IDX_W-1:0] idx;
    logic [`VN_WIDTH-1:0] data;
  } vn_payload_t;

  // IDLE waits for start, SEND issues one word per cycle,
  // DRAIN waits for the transport to empty, FINISH is a single settle cycle
  typedef enum logic [1:0] {
    IDLE,
    SEND,
    DRAIN,
    FINISH
  } vn_state_e;

endpackage

// File: src/vn_xfer_top.sv
/*
  Top of the APB burst mover. APB is exposed as plain ports with no wait
  states. One transfer at a time; there is no abort and no interrupt, so
  software polls STATUS for done.
*/
`timescale 1ns/1ps

`include "vn_cfg.svh"

module vn_xfer_top
  import vn_xfer_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [`VN_AW-1:0]    paddr,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [`VN_WIDTH-1:0] pwdata,
  output logic [`VN_WIDTH-1:0] prdata,
  output logic                 pready,
  output logic                 pslverr
);

  logic                 send_valid_next;
  logic [`VN_IDX_W-1:0] send_idx;
  logic                 src_valid_next;
  logic                 dst_valid_next;
  vn_payload_t          src_payload;
  vn_payload_t          dst_payload;

  vn_ctrl_if ctrl_if ();

  vn_apb_regs u_regs (
    .clk             (clk),
    .reset           (reset),
    .paddr           (paddr),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .ctrl            (ctrl_if.regs),
    .send_valid_next (send_valid_next),
    .send_idx        (send_idx),
    .src_payload     (src_payload),
    .src_valid_next  (src_valid_next),
    .dst_valid_next  (dst_valid_next),
    .dst_payload     (dst_payload)
  );

  vn_xfer_fsm u_fsm (
    .clk             (clk),
    .reset           (reset),
    .ctrl            (ctrl_if.fsm),
    .send_valid_next (send_valid_next),
    .send_idx        (send_idx)
  );

  // Long registered transport between the two buffers
  vn_delay_line #(
    .payload_t  (vn_payload_t),
    .NUM_STAGES (`VN_STAGES)
  ) u_delay (
    .clk            (clk),
    .reset          (reset),
    .in_valid_next  (src_valid_next),
    .in             (src_payload),
    .out_valid_next (dst_valid_next),
    .out            (dst_payload)
  );

endmodule

// File: verif/vn_clk_gen.sv
/*
  Free-running testbench clock. Starts low, first rising edge after half
  a period. HALF_NS sets the half period in ns.
*/
`timescale 1ns/1ps

module vn_clk_gen #(
  parameter int HALF_NS = 2
) (
  output logic clk
);

  // Period is twice the half period, 4 ns by default
  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

endmodule

// File: verif/vn_xfer_assert.sv
/*
  Timing checks for the valid-next delay line. NUM_STAGES must be at
  least 1, since $past needs a positive depth. Checks are off while
  reset is high and rely on reset lasting longer than NUM_STAGES cycles.
*/
`timescale 1ns/1ps

module vn_xfer_assert #(
  parameter type payload_t = logic,
  parameter int  NUM_STAGES = 1
) (
  input logic     clk,
  input logic     reset,
  input logic     in_valid_next,
  input payload_t in,
  input logic     out_valid_next,
  input payload_t out
);

  // The valid_next bit walks the line unchanged, one stage per cycle
  a_valid_delay: assert property (
    @(posedge clk) disable iff (reset)
      out_valid_next == $past(in_valid_next, NUM_STAGES)
  ) else $error("delay line valid_next lost its stage alignment");

  // A word at the far end is the one that entered NUM_STAGES cycles
  // before, seen one cycle after its valid_next
  a_payload_delay: assert property (
    @(posedge clk) disable iff (reset)
      out_valid_next |=> (out == $past(in, NUM_STAGES))
  ) else $error("delay line payload does not match the delayed input");

endmodule

// File: verif/vn_xfer_tb.sv
/*
  Testbench for the APB burst mover. Runs a table of transfers, each with
  a length and the pslverr expected on its start. Inputs change on the
  falling edge; outputs are sampled 1 ns later, before the rising edge.
  Polls STATUS for done, bounded by a global cycle limit.
*/
`timescale 1ns/1ps

`include "vn_cfg.svh"

module vn_xfer_tb
  import vn_apb_pkg::*;
;

  // ------------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------------
  // Probe marks the transfer that gets CTRL and SRC writes while busy
  typedef struct packed {
    logic [3:0] len;
    logic       err;
    logic       probe;
  } entry_t;

  localparam int N_TESTS = 7;
  localparam entry_t TESTS [N_TESTS] = '{
    '{len: 4'd1, err: 1'b0, probe: 1'b0},
    '{len: 4'd8, err: 1'b0, probe: 1'b0},
    '{len: 4'd0, err: 1'b1, probe: 1'b0},
    '{len: 4'd9, err: 1'b1, probe: 1'b0},
    '{len: 4'd8, err: 1'b0, probe: 1'b1},
    '{len: 4'd3, err: 1'b0, probe: 1'b0},
    '{len: 4'd8, err: 1'b0, probe: 1'b0}
  };

  // Setup, access and idle cycle of every APB access
  localparam int APB_CYC      = 3;
  localparam int APB_PER_TEST = 24;
  localparam int EXTRA_APB    = 8;
  localparam int RESET_CYC    = 16;

  logic                 clk;
  logic                 reset;
  logic [`VN_AW-1:0]    paddr;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [`VN_WIDTH-1:0] pwdata;
  logic [`VN_WIDTH-1:0] prdata;
  logic                 pready;
  logic                 pslverr;

  int                   errors;
  int                   checks;
  int                   cycles;
  int                   limit;
  logic [31:0]          rng;
  logic [31:0]          src_model [`VN_DEPTH];
  logic [31:0]          dst_model [`VN_DEPTH];
  logic [`VN_DEPTH-1:0] dst_known;
  logic                 done_flag;

  vn_clk_gen #(.HALF_NS(2)) u_clk (.clk(clk));

  vn_xfer_top dut0 (
    .clk     (clk),
    .reset   (reset),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  bind vn_delay_line vn_xfer_assert #(
    .payload_t  (payload_t),
    .NUM_STAGES (NUM_STAGES)
  ) u_assert (
    .clk            (clk),
    .reset          (reset),
    .in_valid_next  (in_valid_next),
    .in             (in),
    .out_valid_next (out_valid_next),
    .out            (out)
  );

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------
  // Numerical Recipes constants for the 32-bit LCG
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [7:0] word_addr(input logic [7:0] base, input int w);
    return base + 8'(w * 4);
  endfunction

  // Twice the transfer time plus APB traffic plus reset
  function automatic int timeout_limit();
    int sum;
    int i;
    sum = RESET_CYC + EXTRA_APB * APB_CYC;
    for (i = 0; i < N_TESTS; i++) begin
      sum += int'(TESTS[i].len) + `VN_STAGES + 3 + APB_PER_TEST * APB_CYC;
    end
    return 2 * sum;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  // One APB access; the outputs are taken in the middle of the access cycle
  task automatic apb_access(input logic wr, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(negedge clk);
    paddr   = addr;
    pwdata  = wdata;
    pwrite  = wr;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    rdata = prdata;
    err   = pslverr;
    check_value("pready", 32'(pready), 32'd1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // Reads every destination word that has been written at least once
  task automatic check_dst();
    logic [31:0] rd;
    logic        err;
    int          w;
    for (w = 0; w < `VN_DEPTH; w++) begin
      if (dst_known[w]) begin
        apb_access(1'b0, word_addr(DST_BASE, w), 32'd0, rd, err);
        check_value("pslverr", 32'(err), 32'd0);
        check_value($sformatf("prdata DST[%0d]", w), rd, dst_model[w]);
      end
    end
  endtask

  // ------------------------------------------------------------------
  // One table entry: fill SRC, start, watch STATUS, compare DST
  // ------------------------------------------------------------------
  task automatic run_test(input entry_t t);
    logic [31:0] rd;
    logic        err;
    int          w;
    if (!t.err) begin
      for (w = 0; w < `VN_DEPTH; w++) begin
        rng = lcg_next(rng);
        apb_access(1'b1, word_addr(SRC_BASE, w), rng, rd, err);
        check_value("pslverr", 32'(err), 32'd0);
        src_model[w] = rng;
      end
    end
    apb_access(1'b1, CTRL, {27'd0, t.len, 1'b1}, rd, err);
    check_value($sformatf("pslverr CTRL len %0d", t.len), 32'(err), 32'(t.err));
    apb_access(1'b0, STATUS, 32'd0, rd, err);
    if (t.err) begin
      // Refused start leaves the FSM idle and done untouched
      check_value("prdata STATUS", rd, {30'd0, done_flag, 1'b0});
    end else begin
      // Busy is up and the start has cleared done
      check_value("prdata STATUS", rd, 32'h1);
      if (t.probe) begin
        // The last source word is still unread here, so a write that
        // slipped through would show up in the destination
        rng = lcg_next(rng);
        apb_access(1'b1, word_addr(SRC_BASE, `VN_DEPTH - 1), rng, rd, err);
        check_value("pslverr SRC while busy", 32'(err), 32'd1);
        apb_access(1'b1, CTRL, {27'd0, 4'd2, 1'b1}, rd, err);
        check_value("pslverr CTRL while busy", 32'(err), 32'd1);
      end
      do begin
        apb_access(1'b0, STATUS, 32'd0, rd, err);
      end while (rd[0] === 1'b1);
      check_value("prdata STATUS", rd, 32'h2);
      done_flag = 1'b1;
      for (w = 0; w < int'(t.len); w++) begin
        dst_model[w] = src_model[w];
        dst_known[w] = 1'b1;
      end
      check_dst();
    end
  endtask

  // ------------------------------------------------------------------
  // Timeout
  // ------------------------------------------------------------------
  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout: no end of test after %0d cycles", limit);
      $display("Verification failed");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin
    logic [31:0] rd;
    logic        err;
    int          i;
    reset     = 1'b1;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    limit     = timeout_limit();
    rng       = 32'hcfe8ca61;
    dst_known = '0;
    done_flag = 1'b0;

    repeat (RESET_CYC) @(negedge clk);
    reset = 1'b0;

    for (i = 0; i < N_TESTS; i++) begin
      run_test(TESTS[i]);
    end

    // Unmapped read and writes to read-only space are refused with zero data
    apb_access(1'b0, 8'h10, 32'd0, rd, err);
    check_value("pslverr unmapped read", 32'(err), 32'd1);
    check_value("prdata unmapped read", rd, 32'd0);
    apb_access(1'b1, DST_BASE, 32'hdead_beef, rd, err);
    check_value("pslverr DST write", 32'(err), 32'd1);
    check_value("prdata DST write", rd, 32'd0);
    apb_access(1'b1, STATUS, 32'h0000_0003, rd, err);
    check_value("pslverr STATUS write", 32'(err), 32'd1);
    check_value("prdata STATUS write", rd, 32'd0);

    // Neither refused write may have changed anything
    apb_access(1'b0, STATUS, 32'd0, rd, err);
    check_value("prdata STATUS", rd, 32'h2);
    check_dst();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+src
src/vn_apb_pkg.sv
src/vn_xfer_pkg.sv
src/vn_ctrl_if.sv
src/vn_delay_line.sv
src/vn_word_counter.sv
src/vn_xfer_fsm.sv
src/vn_apb_regs.sv
src/vn_xfer_top.sv
verif/vn_clk_gen.sv
verif/vn_xfer_assert.sv
verif/vn_xfer_tb.sv
